/* list.f */
source/switch_pkg.sv
source/ingress_queue_bank.sv
source/crc32_64bit.sv
source/priority_arbiter.sv
source/sched_config.sv
source/sel_control.sv
source/egress_switch_top.sv
testbench/egress_checker.sv
testbench/tb_egress_switch.sv

/* Bender.yml */
package:
  name: egress_switch

sources:
  - files:
      - source/switch_pkg.sv
      - source/ingress_queue_bank.sv
      - source/crc32_64bit.sv
      - source/priority_arbiter.sv
      - source/sched_config.sv
      - source/sel_control.sv
      - source/egress_switch_top.sv
  - target: test
    files:
      - testbench/egress_checker.sv
      - testbench/tb_egress_switch.sv

/* testbench/tb_egress_switch.sv */
`timescale 1ns/1ps
`default_nettype none

module tb_egress_switch;

    localparam int NUM_PORTS  = 4;
    localparam int MAX_CYCLES = 20000;  // bound on the whole run

    typedef struct packed {
        switch_pkg::data_word_t data;
        logic                   sop;
        logic                   eop;
        logic                   err;    // error pulse due after this eop
    } exp_word_t;

    logic                   clk;
    logic                   rst_n;
    logic [NUM_PORTS-1:0]   wr_en;
    switch_pkg::data_word_t wr_data;
    logic [NUM_PORTS-1:0]   full;
    logic                   ready;
    switch_pkg::data_word_t rd_data;
    logic                   rd_vld;
    logic                   rd_sop;
    logic                   rd_eop;
    logic                   error;
    logic                   cfg_we;
    switch_pkg::cfg_addr_t  cfg_addr;
    switch_pkg::cfg_data_t  cfg_wdata;
    switch_pkg::cfg_data_t  cfg_rdata;

    // scoreboard in expected output order
    exp_word_t              exp_mem [256];
    int                     rd_idx = 0;
    int                     wr_idx = 0;
    // one staged frame per port with the header at index 0
    switch_pkg::data_word_t frame_words [NUM_PORTS][128];
    int                     frame_len [NUM_PORTS];
    logic                   frame_bad [NUM_PORTS];
    int                     last_port = NUM_PORTS - 1;  // round robin model
    int                     errors = 0;
    int                     errs_mark = 0;
    int                     n_tests = 0;
    int                     n_failed = 0;
    int                     cycles = 0;
    int                     first;
    int                     seed_ret;
    logic                   writing_done;

    egress_switch_top #(.NUM_PORTS(NUM_PORTS), .QUEUE_DEPTH(16)) DUT (
        .clk       (clk),
        .rst_n     (rst_n),
        .wr_en     (wr_en),
        .wr_data   (wr_data),
        .full      (full),
        .ready     (ready),
        .rd_data   (rd_data),
        .rd_vld    (rd_vld),
        .rd_sop    (rd_sop),
        .rd_eop    (rd_eop),
        .error     (error),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata)
    );

    bind egress_switch_top egress_checker u_checker (
        .clk    (clk),
        .rst_n  (rst_n),
        .rd_vld (rd_vld),
        .rd_sop (rd_sop),
        .rd_eop (rd_eop),
        .error  (error)
    );

    always #5 clk = ~clk;

    always @(posedge clk) begin
        cycles++;
        if (cycles >= MAX_CYCLES) begin
            $display("timeout: the run did not end within %0d cycles", MAX_CYCLES);
            $display("Something failed");
            $finish;
        end
    end

    always @(posedge clk) begin
        if (rst_n && rd_vld)
            rd_idx <= rd_idx + 1;
    end

    //////////////////////////////////////////////////////////////////////
    // output checks against the scoreboard
    //////////////////////////////////////////////////////////////////////
    assert property (@(posedge clk) disable iff (!rst_n) rd_vld |-> rd_idx < wr_idx)
    else begin
        $display("output word at %0t arrived with no word expected", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_vld && rd_idx < wr_idx) |-> rd_data == exp_mem[rd_idx].data &&
            rd_sop == exp_mem[rd_idx].sop && rd_eop == exp_mem[rd_idx].eop)
    else begin
        $display("[FAIL] %0t word %0d got %h sop %b eop %b, expected %h sop %b eop %b",
                 $time, $sampled(rd_idx), $sampled(rd_data), $sampled(rd_sop),
                 $sampled(rd_eop), exp_mem[$sampled(rd_idx)].data,
                 exp_mem[$sampled(rd_idx)].sop, exp_mem[$sampled(rd_idx)].eop);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_eop && rd_idx < wr_idx && exp_mem[rd_idx].err) |-> ##2 error)
    else begin
        $display("[FAIL] %0t no error pulse after a frame with a bad crc", $time);
        errors++;
    end

    assert property (@(posedge clk) disable iff (!rst_n)
        (rd_eop && rd_idx < wr_idx && !exp_mem[rd_idx].err) |-> ##2 !error)
    else begin
        $display("[FAIL] %0t error pulse after a frame with a good crc", $time);
        errors++;
    end

    // failures seen here and in the bound checker
    function automatic int total_errors();
        return errors + DUT.u_checker.fail_cnt;
    endfunction

    // reflected crc-32 taking bit 0 of each word first
    function automatic switch_pkg::crc_t crc_fold(input switch_pkg::crc_t c,
                                                  input switch_pkg::data_word_t w);
        switch_pkg::crc_t r;
        r = c;
        for (int b = 0; b < 64; b++)
            r = (r[0] ^ w[b]) ? ((r >> 1) ^ switch_pkg::CRC_POLY) : (r >> 1);
        return r;
    endfunction

    task automatic make_frame(input int p, input int prio, input int cnt, input logic bad);
        switch_pkg::pkt_hdr_t hdr;
        switch_pkg::crc_t     crc;
        crc = switch_pkg::CRC_INIT;
        for (int i = 1; i <= cnt; i++) begin
            frame_words[p][i] = {$urandom, $urandom};
            crc = crc_fold(crc, frame_words[p][i]);
        end
        hdr.prio          = switch_pkg::prio_t'(prio);
        hdr.crc           = crc ^ switch_pkg::CRC_XOR_OUT ^ {31'd0, bad};  // bad flips bit 0
        hdr.frame_cnt     = switch_pkg::frame_cnt_t'(cnt);
        frame_words[p][0] = switch_pkg::data_word_t'(hdr);
        frame_len[p]      = cnt + 1;
        frame_bad[p]      = bad;
    endtask

    // payload of the staged frame goes to the scoreboard
    task automatic release_port(input int p);
        for (int i = 1; i < frame_len[p]; i++) begin
            exp_mem[wr_idx].data = frame_words[p][i];
            exp_mem[wr_idx].sop  = (i == 1);
            exp_mem[wr_idx].eop  = (i == frame_len[p] - 1);
            exp_mem[wr_idx].err  = frame_bad[p];
            wr_idx++;
        end
        last_port = p;
    endtask

    task automatic write_frame(input int p, input int gap);
        for (int i = 0; i < frame_len[p]; i++) begin
            @(posedge clk);
            #1;
            wr_en   = NUM_PORTS'(1) << p;
            wr_data = frame_words[p][i];
            repeat (gap) begin
                @(posedge clk);
                #1;
                wr_en = '0;
            end
        end
        @(posedge clk);
        #1;
        wr_en = '0;
    endtask

    task automatic set_ready(input logic value);
        @(posedge clk);
        #1;
        ready = value;
    endtask

    task automatic write_reg(input switch_pkg::cfg_addr_t addr, input int value);
        @(posedge clk);
        #1;
        cfg_we    = 1'b1;
        cfg_addr  = addr;
        cfg_wdata = switch_pkg::cfg_data_t'(value);
        @(posedge clk);
        #1;
        cfg_we = 1'b0;
    endtask

    task automatic check_reg(input switch_pkg::cfg_addr_t addr, input int expected);
        @(posedge clk);
        #1;
        cfg_addr = addr;
        @(negedge clk);
        assert (cfg_rdata == expected)
        else begin
            $display("[FAIL] %0t register %0d reads %0d, expected %0d",
                     $time, addr, cfg_rdata, expected);
            errors++;
        end
    endtask

    task automatic check_full(input logic [NUM_PORTS-1:0] expected);
        @(negedge clk);
        assert (full == expected)
        else begin
            $display("[FAIL] %0t full is %b, expected %b", $time, full, expected);
            errors++;
        end
    endtask

    task automatic wait_drain();
        while (rd_idx != wr_idx)
            @(posedge clk);
        repeat (4) @(posedge clk);  // room for the error pulse
    endtask

    task automatic finish_test(input string name);
        n_tests++;
        if (total_errors() != errs_mark) begin
            n_failed++;
            $display("test %0d %s: failed", n_tests, name);
        end else begin
            $display("test %0d %s: passed", n_tests, name);
        end
        errs_mark = total_errors();
    endtask

    initial begin
        seed_ret  = $urandom(32'hc73d_042a);
        clk       = 1'b0;
        rst_n     = 1'b0;
        wr_en     = '0;
        wr_data   = '0;
        ready     = 1'b1;
        cfg_we    = 1'b0;
        cfg_addr  = '0;
        cfg_wdata = '0;
        repeat (16) @(posedge clk);
        #1;
        rst_n = 1'b1;

        make_frame(2, 5, 6, 1'b0);
        release_port(2);
        write_frame(2, 0);
        wait_drain();
        finish_test("single frame");

        ///////////////////////////////////////////////////////////////////
        // arbitration order with all queues loaded while ready is low
        ///////////////////////////////////////////////////////////////////
        set_ready(1'b0);
        make_frame(0, 3, 3, 1'b0);
        make_frame(1, 6, 4, 1'b0);
        make_frame(2, 6, 2, 1'b0);
        make_frame(3, 1, 5, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++)
            write_frame(p, 0);
        release_port(1);    // lower index wins the priority 6 tie
        release_port(2);
        release_port(0);
        release_port(3);
        set_ready(1'b1);
        wait_drain();
        finish_test("fixed priority");

        write_reg(switch_pkg::ADDR_SCHEME, 1);
        set_ready(1'b0);
        make_frame(0, 7, 2, 1'b0);
        make_frame(1, 0, 3, 1'b0);
        make_frame(2, 4, 4, 1'b0);
        make_frame(3, 2, 2, 1'b0);
        for (int p = 0; p < NUM_PORTS; p++)
            write_frame(p, 0);
        first = last_port;
        for (int k = 1; k <= NUM_PORTS; k++)
            release_port((first + k) % NUM_PORTS);
        set_ready(1'b1);
        wait_drain();
        finish_test("round robin");

        make_frame(0, 2, 5, 1'b1);
        release_port(0);
        write_frame(0, 0);
        wait_drain();
        check_reg(switch_pkg::ADDR_ERR_CNT, 1);
        write_reg(switch_pkg::ADDR_ERR_CNT, 0);
        check_reg(switch_pkg::ADDR_ERR_CNT, 0);
        finish_test("crc error");

        // slow writer against random back-pressure
        writing_done = 1'b0;
        fork
            begin
                make_frame(1, 2, 12, 1'b0);
                release_port(1);
                write_frame(1, 3);
                make_frame(1, 4, 5, 1'b0);
                release_port(1);
                write_frame(1, 2);
                writing_done = 1'b1;
            end
            begin
                while (!writing_done) begin
                    @(posedge clk);
                    #1;
                    ready = 1'($urandom);
                end
            end
        join
        set_ready(1'b1);
        wait_drain();
        finish_test("underrun and back-pressure");

        // a full queue ignores further writes
        set_ready(1'b0);
        make_frame(3, 1, 15, 1'b0);
        write_frame(3, 0);
        check_full(NUM_PORTS'(1) << 3);
        @(posedge clk);
        #1;
        wr_en   = NUM_PORTS'(1) << 3;
        wr_data = '1;
        @(posedge clk);
        #1;
        wr_en = '0;
        release_port(3);
        set_ready(1'b1);
        wait_drain();
        check_full('0);
        finish_test("full queue");

        write_reg(switch_pkg::ADDR_PORT_MASK, 4'b1011);
        make_frame(2, 3, 4, 1'b0);
        write_frame(2, 0);
        repeat (60) @(posedge clk);  // masked frame must stay put
        release_port(2);
        write_reg(switch_pkg::ADDR_PORT_MASK, 4'b1111);
        wait_drain();
        finish_test("port mask");

        $display("tests %0d, failed %0d, errors %0d", n_tests, n_failed, total_errors());
        if (total_errors() == 0)
            $display("Everything OK");
        else
            $display("Something failed");
        $finish;
    end

endmodule

`default_nettype wire

/* testbench/egress_checker.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_checker (
    input wire clk,
    input wire rst_n,
    input wire rd_vld,
    input wire rd_sop,
    input wire rd_eop,
    input wire error
);

    logic in_frame;     // between sop and eop
    int   fail_cnt = 0;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n)
            in_frame <= 1'b0;
        else if (rd_eop)
            in_frame <= 1'b0;
        else if (rd_sop)
            in_frame <= 1'b1;
    end

    //////////////////////////////////////////////////////////////////////
    // output framing
    //////////////////////////////////////////////////////////////////////
    sop_needs_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_sop |-> rd_vld)
        else begin
            $error("rd_sop without rd_vld");
            fail_cnt++;
        end
    eop_needs_vld: assert property (@(posedge clk) disable iff (!rst_n) rd_eop |-> rd_vld)
        else begin
            $error("rd_eop without rd_vld");
            fail_cnt++;
        end
    one_sop: assert property (@(posedge clk) disable iff (!rst_n) in_frame |-> !rd_sop)
        else begin
            $error("second rd_sop before rd_eop");
            fail_cnt++;
        end

    // error trails the eop by two cycles
    error_after_eop: assert property (@(posedge clk) disable iff (!rst_n)
        error |-> $past(rd_eop, 2))
        else begin
            $error("error without rd_eop two cycles before");
            fail_cnt++;
        end

    quiet_in_reset: assert property (@(posedge clk)
        !rst_n |-> !(rd_vld || rd_sop || rd_eop || error))
        else begin
            $error("output strobe high during reset");
            fail_cnt++;
        end

endmodule

`default_nettype wire

/* source/egress_switch_top.sv */
`timescale 1ns/1ps
`default_nettype none

module egress_switch_top #(
    parameter int NUM_PORTS   = 4,
    parameter int QUEUE_DEPTH = 16
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [NUM_PORTS-1:0]         wr_en,
    input  wire  switch_pkg::data_word_t wr_data,
    output logic [NUM_PORTS-1:0]         full,
    input  wire                          ready,
    output switch_pkg::data_word_t       rd_data,
    output logic                         rd_vld,
    output logic                         rd_sop,
    output logic                         rd_eop,
    output logic                         error,
    input  wire                          cfg_we,
    input  wire  switch_pkg::cfg_addr_t  cfg_addr,
    input  wire  switch_pkg::cfg_data_t  cfg_wdata,
    output switch_pkg::cfg_data_t        cfg_rdata
);

    localparam int PORT_W = $clog2(NUM_PORTS);

    logic [NUM_PORTS-1:0]              empty;
    logic                              rd_en;
    logic [PORT_W-1:0]                 rd_sel;
    switch_pkg::data_word_t            q_data;
    logic                              arb_en;
    logic [NUM_PORTS-1:0]              request;
    switch_pkg::prio_t [NUM_PORTS-1:0] priorities;
    logic [PORT_W-1:0]                 grant;
    logic                              grant_vld;
    switch_pkg::sched_mode_e           mode;
    logic [NUM_PORTS-1:0]              port_mask;
    logic                              crc_clr;
    logic                              crc_en;
    logic                              crc_err;
    switch_pkg::crc_t                  crc_out;

    ingress_queue_bank #(.NUM_PORTS(NUM_PORTS), .QUEUE_DEPTH(QUEUE_DEPTH)) u_queues (
        .clk     (clk),
        .rst_n   (rst_n),
        .wr_en   (wr_en),
        .wr_data (wr_data),
        .full    (full),
        .empty   (empty),
        .rd_en   (rd_en),
        .rd_sel  (rd_sel),
        .q_data  (q_data)
    );

    sel_control #(.NUM_PORTS(NUM_PORTS)) u_sched (
        .clk        (clk),
        .rst_n      (rst_n),
        .ready      (ready),
        .empty      (empty),
        .q_data     (q_data),
        .port_mask  (port_mask),
        .rd_en      (rd_en),
        .rd_sel     (rd_sel),
        .arb_en     (arb_en),
        .request    (request),
        .priorities (priorities),
        .grant      (grant),
        .grant_vld  (grant_vld),
        .crc_clr    (crc_clr),
        .crc_en     (crc_en),
        .crc_out    (crc_out),
        .rd_data    (rd_data),
        .rd_vld     (rd_vld),
        .rd_sop     (rd_sop),
        .rd_eop     (rd_eop),
        .error      (error),
        .crc_err    (crc_err)
    );

    priority_arbiter #(.NUM_PORTS(NUM_PORTS)) u_arb (
        .clk        (clk),
        .rst_n      (rst_n),
        .arb_en     (arb_en),
        .request    (request),
        .priorities (priorities),
        .mode       (mode),
        .grant      (grant),
        .grant_vld  (grant_vld)
    );

    sched_config #(.NUM_PORTS(NUM_PORTS)) u_cfg (
        .clk       (clk),
        .rst_n     (rst_n),
        .cfg_we    (cfg_we),
        .cfg_addr  (cfg_addr),
        .cfg_wdata (cfg_wdata),
        .cfg_rdata (cfg_rdata),
        .mode      (mode),
        .port_mask (port_mask),
        .crc_err   (crc_err)
    );

    crc32_64bit u_crc (
        .clk     (clk),
        .rst_n   (rst_n),
        .crc_clr (crc_clr),
        .crc_en  (crc_en),
        .data    (rd_data),
        .crc_out (crc_out)
    );

endmodule

`default_nettype wire

/* source/sel_control.sv */
`timescale 1ns/1ps
`default_nettype none

module sel_control #(
    parameter int  NUM_PORTS = 4,
    localparam int PORT_W    = $clog2(NUM_PORTS)
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 ready,
    input  wire  [NUM_PORTS-1:0]                empty,
    input  wire  switch_pkg::data_word_t        q_data,
    input  wire  [NUM_PORTS-1:0]                port_mask,
    output logic                                rd_en,
    output logic [PORT_W-1:0]                   rd_sel,
    output logic                                arb_en,
    output logic [NUM_PORTS-1:0]                request,
    output switch_pkg::prio_t [NUM_PORTS-1:0]   priorities,
    input  wire  [PORT_W-1:0]                   grant,
    input  wire                                 grant_vld,
    output logic                                crc_clr,
    output logic                                crc_en,
    input  wire  switch_pkg::crc_t              crc_out,
    output switch_pkg::data_word_t              rd_data,
    output logic                                rd_vld,
    output logic                                rd_sop,
    output logic                                rd_eop,
    output logic                                error,
    output logic                                crc_err
);

    switch_pkg::sched_state_e state;
    switch_pkg::pkt_hdr_t     hdr [NUM_PORTS];  // stored header per port
    logic [NUM_PORTS-1:0]     hdr_vld;
    logic [PORT_W-1:0]        scan_ptr;
    logic [PORT_W-1:0]        scan_next;
    logic [PORT_W-1:0]        gnt_port;
    switch_pkg::frame_cnt_t   words_left;       // payload words still to read
    logic                     first_word;
    logic                     eop_q;            // crc_out is final here
    logic                     hdr_rd;
    logic                     pay_rd;
    logic                     unread;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            request[i]    = hdr_vld[i] && port_mask[i];
            priorities[i] = hdr[i].prio;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // read strobes, only while ready is high
    //////////////////////////////////////////////////////////////////////
    assign unread    = |(~hdr_vld & ~empty);    // a queue with a header not yet taken
    assign hdr_rd    = (state == switch_pkg::ST_SCAN) && ready &&
                       !hdr_vld[scan_ptr] && !empty[scan_ptr];
    assign pay_rd    = (state == switch_pkg::ST_SEND) && ready &&
                       !empty[gnt_port] && (words_left != '0);
    assign rd_en     = hdr_rd || pay_rd;
    assign rd_sel    = (state == switch_pkg::ST_SEND) ? gnt_port : scan_ptr;
    assign scan_next = (scan_ptr == PORT_W'(NUM_PORTS - 1)) ? '0 : scan_ptr + 1'b1;

    assign rd_data = q_data;
    assign crc_en  = rd_vld;                    // word sits on q_data now
    assign crc_clr = (state == switch_pkg::ST_ARB);
    assign crc_err = error;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state      <= switch_pkg::ST_SCAN;
            hdr_vld    <= '0;
            scan_ptr   <= '0;
            gnt_port   <= '0;
            words_left <= '0;
            first_word <= 1'b0;
            arb_en     <= 1'b0;
            rd_vld     <= 1'b0;
            rd_sop     <= 1'b0;
            rd_eop     <= 1'b0;
            eop_q      <= 1'b0;
            error      <= 1'b0;
        end else begin
            arb_en <= 1'b0;
            error  <= 1'b0;
            rd_vld <= pay_rd;
            rd_sop <= pay_rd && first_word;
            rd_eop <= pay_rd && (words_left == switch_pkg::frame_cnt_t'(1));
            eop_q  <= rd_eop;
            case (state)
                switch_pkg::ST_SCAN: begin
                    if (hdr_rd) begin
                        state <= switch_pkg::ST_HDR_WAIT;
                    end else if (!unread && (|request)) begin
                        arb_en <= 1'b1;
                        state  <= switch_pkg::ST_ARB;
                    end else begin
                        scan_ptr <= scan_next;
                    end
                end
                switch_pkg::ST_HDR_WAIT: begin      // header is on q_data
                    hdr_vld[scan_ptr] <= 1'b1;
                    scan_ptr          <= scan_next;
                    state             <= switch_pkg::ST_SCAN;
                end
                switch_pkg::ST_ARB: begin
                    if (grant_vld) begin
                        gnt_port   <= grant;
                        words_left <= hdr[grant].frame_cnt;
                        first_word <= 1'b1;
                        state      <= switch_pkg::ST_SEND;
                    end else if (!arb_en) begin
                        state <= switch_pkg::ST_SCAN;   // mask took the request away
                    end
                end
                switch_pkg::ST_SEND: begin
                    if (pay_rd) begin
                        words_left <= words_left - 1'b1;
                        first_word <= 1'b0;
                    end
                    if (eop_q) begin
                        error             <= (crc_out != hdr[gnt_port].crc);
                        hdr_vld[gnt_port] <= 1'b0;
                        state             <= switch_pkg::ST_SCAN;
                    end
                end
                default: state <= switch_pkg::ST_SCAN;
            endcase
        end
    end

    // header capture
    always_ff @(posedge clk) begin
        if (state == switch_pkg::ST_HDR_WAIT)
            hdr[scan_ptr] <= q_data[$bits(switch_pkg::pkt_hdr_t)-1:0];
    end

endmodule

`default_nettype wire

/* source/sched_config.sv */
`timescale 1ns/1ps
`default_nettype none

module sched_config #(
    parameter int NUM_PORTS = 4
) (
    input  wire                           clk,
    input  wire                           rst_n,
    input  wire                           cfg_we,
    input  wire  switch_pkg::cfg_addr_t   cfg_addr,
    input  wire  switch_pkg::cfg_data_t   cfg_wdata,
    output switch_pkg::cfg_data_t         cfg_rdata,
    output switch_pkg::sched_mode_e       mode,
    output logic [NUM_PORTS-1:0]          port_mask,
    input  wire                           crc_err
);

    switch_pkg::cfg_data_t err_cnt;    // saturates at all ones

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            mode      <= switch_pkg::MODE_FIXED;
            port_mask <= '1;               // all ports served
            err_cnt   <= '0;
        end else begin
            if (cfg_we && cfg_addr == switch_pkg::ADDR_SCHEME)
                mode <= switch_pkg::sched_mode_e'(cfg_wdata[0]);
            if (cfg_we && cfg_addr == switch_pkg::ADDR_PORT_MASK)
                port_mask <= cfg_wdata[NUM_PORTS-1:0];
            if (cfg_we && cfg_addr == switch_pkg::ADDR_ERR_CNT)
                err_cnt <= '0;             // any write clears
            else if (crc_err && err_cnt != '1)
                err_cnt <= err_cnt + 1'b1;
        end
    end

    always_comb begin
        case (cfg_addr)
            switch_pkg::ADDR_SCHEME:    cfg_rdata = switch_pkg::cfg_data_t'(mode);
            switch_pkg::ADDR_PORT_MASK: cfg_rdata = switch_pkg::cfg_data_t'(port_mask);
            switch_pkg::ADDR_ERR_CNT:   cfg_rdata = err_cnt;
            default:                    cfg_rdata = '0;
        endcase
    end

endmodule

`default_nettype wire

/* source/priority_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module priority_arbiter #(
    parameter int  NUM_PORTS = 4,
    localparam int PORT_W    = $clog2(NUM_PORTS)
) (
    input  wire                                 clk,
    input  wire                                 rst_n,
    input  wire                                 arb_en,
    input  wire  [NUM_PORTS-1:0]                request,
    input  wire  switch_pkg::prio_t [NUM_PORTS-1:0] priorities,
    input  wire  switch_pkg::sched_mode_e       mode,
    output logic [PORT_W-1:0]                   grant,
    output logic                                grant_vld
);

    logic [PORT_W-1:0] last_grant;     // round robin pointer
    logic [PORT_W-1:0] fixed_pick;
    logic [PORT_W-1:0] rr_pick;
    logic [PORT_W-1:0] rr_idx;
    logic [PORT_W-1:0] pick;
    switch_pkg::prio_t best_prio;
    logic              found;
    logic              rr_found;

    // strict compare keeps the lowest index on a tie
    always_comb begin
        fixed_pick = '0;
        best_prio  = '0;
        found      = 1'b0;
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (request[i] && (!found || priorities[i] > best_prio)) begin
                fixed_pick = PORT_W'(i);
                best_prio  = priorities[i];
                found      = 1'b1;
            end
        end
    end

    // first requester after the last grant, priority ignored
    always_comb begin
        rr_pick  = last_grant;
        rr_found = 1'b0;
        rr_idx   = last_grant;
        for (int k = 1; k <= NUM_PORTS; k++) begin
            rr_idx = PORT_W'((int'(last_grant) + k) % NUM_PORTS);
            if (request[rr_idx] && !rr_found) begin
                rr_pick  = rr_idx;
                rr_found = 1'b1;
            end
        end
    end

    assign pick = (mode == switch_pkg::MODE_RR) ? rr_pick : fixed_pick;

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            grant      <= '0;
            grant_vld  <= 1'b0;
            last_grant <= PORT_W'(NUM_PORTS - 1);  // so port 0 goes first
        end else begin
            grant_vld <= arb_en && (|request);
            if (arb_en && (|request)) begin
                grant      <= pick;
                last_grant <= pick;
            end
        end
    end

endmodule

`default_nettype wire

/* source/crc32_64bit.sv */
`timescale 1ns/1ps
`default_nettype none

module crc32_64bit (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire                          crc_clr,
    input  wire                          crc_en,
    input  wire  switch_pkg::data_word_t data,
    output switch_pkg::crc_t             crc_out
);

    switch_pkg::crc_t crc_q;
    switch_pkg::crc_t crc_next;

    // fold the whole word, bit 0 first
    always_comb begin
        crc_next = crc_q;
        for (int b = 0; b < $bits(data); b++) begin
            if (crc_next[0] ^ data[b])
                crc_next = (crc_next >> 1) ^ switch_pkg::CRC_POLY;
            else
                crc_next = crc_next >> 1;
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            crc_q <= switch_pkg::CRC_INIT;
        end else if (crc_clr) begin
            crc_q <= switch_pkg::CRC_INIT;  // new frame
        end else if (crc_en) begin
            crc_q <= crc_next;
        end
    end

    assign crc_out = crc_q ^ switch_pkg::CRC_XOR_OUT;

endmodule

`default_nettype wire

/* source/ingress_queue_bank.sv */
`timescale 1ns/1ps
`default_nettype none

module ingress_queue_bank #(
    parameter int  NUM_PORTS   = 4,
    parameter int  QUEUE_DEPTH = 16,
    localparam int PORT_W      = $clog2(NUM_PORTS)
) (
    input  wire                          clk,
    input  wire                          rst_n,
    input  wire  [NUM_PORTS-1:0]         wr_en,
    input  wire  switch_pkg::data_word_t wr_data,
    output logic [NUM_PORTS-1:0]         full,
    output logic [NUM_PORTS-1:0]         empty,
    input  wire                          rd_en,
    input  wire  [PORT_W-1:0]            rd_sel,
    output switch_pkg::data_word_t       q_data
);

    localparam int PTR_W = $clog2(QUEUE_DEPTH);

    switch_pkg::data_word_t mem [NUM_PORTS][QUEUE_DEPTH];
    logic [PTR_W:0]         wr_ptr [NUM_PORTS];    // msb is the wrap bit
    logic [PTR_W:0]         rd_ptr [NUM_PORTS];
    logic [NUM_PORTS-1:0]   push;
    logic [NUM_PORTS-1:0]   pop;

    always_comb begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            empty[i] = (wr_ptr[i] == rd_ptr[i]);
            full[i]  = (wr_ptr[i][PTR_W] != rd_ptr[i][PTR_W]) &&
                       (wr_ptr[i][PTR_W-1:0] == rd_ptr[i][PTR_W-1:0]);
            push[i]  = wr_en[i] && !full[i];    // write into a full queue is lost
            pop[i]   = rd_en && (rd_sel == PORT_W'(i)) && !empty[i];
        end
    end

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                wr_ptr[i] <= '0;
                rd_ptr[i] <= '0;
            end
        end else begin
            for (int i = 0; i < NUM_PORTS; i++) begin
                if (push[i])
                    wr_ptr[i] <= wr_ptr[i] + 1'b1;
                if (pop[i])
                    rd_ptr[i] <= rd_ptr[i] + 1'b1;
            end
        end
    end

    //////////////////////////////////////////////////////////////////////
    // storage and registered read mux
    //////////////////////////////////////////////////////////////////////
    always_ff @(posedge clk) begin
        for (int i = 0; i < NUM_PORTS; i++) begin
            if (push[i])
                mem[i][wr_ptr[i][PTR_W-1:0]] <= wr_data;
        end
        if (rd_en)
            q_data <= mem[rd_sel][rd_ptr[rd_sel][PTR_W-1:0]];   // one cycle after rd_en
    end

endmodule

`default_nettype wire

/* source/switch_pkg.sv */
`default_nettype none

package switch_pkg;

    //////////////////////////////////////////////////////////////////////
    // word and field widths
    //////////////////////////////////////////////////////////////////////
    typedef logic [63:0] data_word_t;   // queue and output word
    typedef logic [2:0]  prio_t;        // larger is more urgent
    typedef logic [31:0] crc_t;
    typedef logic [6:0]  frame_cnt_t;   // payload words, 1 to 127
    typedef logic [1:0]  cfg_addr_t;
    typedef logic [15:0] cfg_data_t;

    // low 42 bits of a header word, upper bits zero
    typedef struct packed {
        frame_cnt_t frame_cnt;
        crc_t       crc;
        prio_t      prio;
    } pkt_hdr_t;

    typedef enum logic {
        MODE_FIXED = 1'b0,
        MODE_RR    = 1'b1
    } sched_mode_e;

    typedef enum logic [1:0] {
        ST_SCAN,
        ST_HDR_WAIT,
        ST_ARB,
        ST_SEND
    } sched_state_e;

    // register map
    localparam cfg_addr_t ADDR_SCHEME    = 2'd0;
    localparam cfg_addr_t ADDR_PORT_MASK = 2'd1;
    localparam cfg_addr_t ADDR_ERR_CNT   = 2'd2;

    // crc-32, reflected, lsb first
    localparam crc_t CRC_INIT    = 32'hFFFF_FFFF;
    localparam crc_t CRC_POLY    = 32'hEDB8_8320;
    localparam crc_t CRC_XOR_OUT = 32'hFFFF_FFFF;

endpackage

`default_nettype wire
